//--- logic/lsu_pkg.sv
// Shared widths, queue depth and types of the store side of the load/store unit
// Addresses are byte addresses and the memory write port works on 32-bit words
// Only aligned accesses are supported, the low address bits are trusted
`default_nettype none

package lsu_pkg;

    localparam int SQ_DEPTH  = 8;
    localparam int SQ_IDX_W  = $clog2(SQ_DEPTH);
    localparam int ADDR_W    = 16;
    localparam int DATA_W    = 32;
    localparam int TAG_W     = 6;
    localparam int BYTE_EN_W = DATA_W / 8;

    typedef logic [ADDR_W-1:0]    lsu_addr_t;
    // Word address as seen by the memory write port
    typedef logic [ADDR_W-3:0]    lsu_word_addr_t;
    typedef logic [DATA_W-1:0]    lsu_data_t;
    typedef logic [TAG_W-1:0]     lsu_tag_t;
    typedef logic [SQ_DEPTH-1:0]  sq_select_t;
    typedef logic [SQ_IDX_W-1:0]  sq_idx_t;
    typedef logic [BYTE_EN_W-1:0] byte_en_t;

    // The store kinds are byte, halfword and word
    typedef enum logic [1:0] {
        SB = 2'b00,
        SH = 2'b01,
        SW = 2'b10
    } lsu_func_t;

    // States of the commit stage
    typedef enum logic {
        IDLE  = 1'b0,
        WRITE = 1'b1
    } commit_state_t;

endpackage

`default_nettype wire

//--- logic/lsu_ifs.sv
// Interfaces between the store stages
// sq_alloc_if takes a store into the queue when en is high and full is low
// sq_retire_if carries one launched store; the consumer holds it with stall
`default_nettype none

// Allocation bus from the address generation stage into the store queue
interface sq_alloc_if import lsu_pkg::*; ();

    logic      en;
    lsu_func_t func;
    lsu_tag_t  tag;
    lsu_addr_t addr;
    lsu_data_t data;
    logic      full;

    // The producer side forms the store op
    modport agu (
        output en, func, tag, addr, data,
        input  full
    );

    // The queue side reports when no slot is free
    modport sq (
        input  en, func, tag, addr, data,
        output full
    );

endinterface

// Retire bus from the store queue into the commit stage
interface sq_retire_if import lsu_pkg::*; ();

    logic       en;
    sq_select_t select;
    lsu_func_t  func;
    lsu_addr_t  addr;
    lsu_tag_t   tag;
    lsu_data_t  data;
    logic       stall;

    modport sq (
        output en, select, func, addr, tag, data,
        input  stall
    );

    // The commit stage stalls the queue while it holds a store
    modport commit (
        input  en, select, func, addr, tag, data,
        output stall
    );

endinterface

`default_nettype wire

//--- logic/store_agu.sv
// Address generation stage that holds one store op
// The address wraps at ADDR_W bits and is not checked for alignment
// A flush drops the held op and any issue in the same cycle
`default_nettype none

module store_agu import lsu_pkg::*; (
    input  logic        clk,
    input  logic        n_rst,
    input  logic        i_flush,
    input  logic        i_issue_en,
    input  lsu_func_t   i_issue_func,
    input  lsu_tag_t    i_issue_tag,
    input  lsu_addr_t   i_issue_base,
    input  lsu_addr_t   i_issue_offset,
    input  lsu_data_t   i_issue_data,
    output logic        o_issue_ready,
    sq_alloc_if.agu     alloc
);

    logic      op_valid;
    lsu_func_t op_func;
    lsu_tag_t  op_tag;
    lsu_addr_t op_addr;
    lsu_data_t op_data;

    // The stage only blocks when its held op cannot enter the queue
    assign o_issue_ready = ~(op_valid & alloc.full);

    // The op is offered only while the queue has room
    assign alloc.en   = op_valid & ~alloc.full;
    assign alloc.func = op_func;
    assign alloc.tag  = op_tag;
    assign alloc.addr = op_addr;
    assign alloc.data = op_data;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            op_valid <= 1'b0;
        end else if (i_flush) begin
            op_valid <= 1'b0;
        end else if (o_issue_ready) begin
            op_valid <= i_issue_en;
        end
    end

    // Payload only changes when a new op is accepted
    always_ff @(posedge clk) begin
        if (o_issue_ready && i_issue_en) begin
            op_func <= i_issue_func;
            op_tag  <= i_issue_tag;
            op_addr <= i_issue_base + i_issue_offset;
            op_data <= i_issue_data;
        end
    end

endmodule

`default_nettype wire

//--- logic/lsu_sq.sv
// Store queue with SQ_DEPTH slots
// Stores become nonspeculative one at a time, in reorder buffer retirement order
// A flush keeps nonspeculative stores and never cancels a launched one
// The reorder buffer must hold its retire request until it sees the ack
`default_nettype none

module lsu_sq import lsu_pkg::*; (
    input  logic        clk,
    input  logic        n_rst,
    input  logic        i_flush,
    sq_alloc_if.sq      alloc,
    sq_retire_if.sq     retire,
    input  logic        i_update_en,
    input  sq_select_t  i_update_select,
    input  logic        i_update_retry,
    input  logic        i_rob_retire_en,
    input  lsu_tag_t    i_rob_retire_tag,
    output logic        o_rob_retire_ack
);

    // Slot payload
    lsu_func_t  slot_func [SQ_DEPTH];
    lsu_addr_t  slot_addr [SQ_DEPTH];
    lsu_data_t  slot_data [SQ_DEPTH];
    lsu_tag_t   slot_tag  [SQ_DEPTH];

    // Slot control bits
    sq_select_t slot_valid;
    sq_select_t slot_nonspec;
    sq_select_t slot_launched;

    sq_select_t free_vec;
    sq_select_t alloc_select;
    sq_select_t rob_select;
    sq_select_t retirable;
    sq_select_t launch_select;
    sq_select_t upd_select;
    sq_select_t upd_done;
    sq_select_t upd_again;
    sq_select_t keep_mask;
    sq_idx_t    launch_idx;
    logic       launch_en;
    logic       retire_busy;

    assign free_vec   = ~slot_valid;
    assign alloc.full = &slot_valid;

    // Lowest free slot takes the new store, a flush drops it as speculative
    assign alloc_select = {SQ_DEPTH{alloc.en & ~alloc.full & ~i_flush}} &
                          (free_vec & ~(free_vec - 1'b1));

    // A store still retiring blocks the next one from turning nonspeculative
    // This keeps launches in retirement order even across retries
    assign retire_busy = |(slot_valid & slot_nonspec);

    always_comb begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            rob_select[i] = i_rob_retire_en & ~retire_busy & slot_valid[i] &
                            (slot_tag[i] == i_rob_retire_tag);
        end
    end

    // Retirable means valid, nonspeculative and not yet launched
    assign retirable     = slot_valid & slot_nonspec & ~slot_launched;
    assign launch_select = {SQ_DEPTH{~retire.stall}} & (retirable & ~(retirable - 1'b1));
    assign launch_en     = |launch_select;

    // One-hot launch select to slot index
    always_comb begin
        launch_idx = '0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (launch_select[i]) begin
                launch_idx = sq_idx_t'(i);
            end
        end
    end

    // The commit stage result either frees the slot or launches it again
    assign upd_select = {SQ_DEPTH{i_update_en}} & i_update_select;
    assign upd_done   = upd_select & {SQ_DEPTH{~i_update_retry}};
    assign upd_again  = upd_select & {SQ_DEPTH{i_update_retry}};

    // On flush only stores already retired, or retiring now, survive
    assign keep_mask = i_flush ? (slot_nonspec | rob_select) : '1;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            slot_valid    <= '0;
            slot_nonspec  <= '0;
            slot_launched <= '0;
        end else begin
            slot_valid    <= (slot_valid & keep_mask & ~upd_done) | alloc_select;
            slot_nonspec  <= (slot_nonspec & ~alloc_select) | rob_select;
            slot_launched <= (slot_launched & ~alloc_select & ~upd_again) | launch_select;
        end
    end

    // New store ops write their payload into the chosen slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (alloc_select[i]) begin
                slot_func[i] <= alloc.func;
                slot_addr[i] <= alloc.addr;
                slot_data[i] <= alloc.data;
                slot_tag[i]  <= alloc.tag;
            end
        end
    end

    // Retire outputs hold while the commit stage stalls
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            retire.en <= 1'b0;
        end else if (!retire.stall) begin
            retire.en <= launch_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!retire.stall) begin
            retire.select <= launch_select;
            retire.func   <= slot_func[launch_idx];
            retire.addr   <= slot_addr[launch_idx];
            retire.tag    <= slot_tag[launch_idx];
            retire.data   <= slot_data[launch_idx];
        end
    end

    // Ack the reorder buffer on the first launch of the store it is retiring
    // A relaunch after retry carries an older tag, so it never acks twice
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_rob_retire_ack <= 1'b0;
        end else begin
            o_rob_retire_ack <= launch_en & i_rob_retire_en &
                                (slot_tag[launch_idx] == i_rob_retire_tag);
        end
    end

endmodule

`default_nettype wire

//--- logic/store_commit.sv
// Commit stage with one store in flight
// Byte lanes come from the low two address bits, which are assumed aligned
// Memory busy in the WRITE cycle turns the write into a retry
`default_nettype none

module store_commit import lsu_pkg::*; (
    input  logic            clk,
    input  logic            n_rst,
    input  logic            i_mem_busy,
    sq_retire_if.commit     retire,
    output logic            o_update_en,
    output sq_select_t      o_update_select,
    output logic            o_update_retry,
    output logic            o_commit_en,
    output lsu_word_addr_t  o_commit_addr,
    output byte_en_t        o_commit_byte_en,
    output lsu_data_t       o_commit_data
);

    commit_state_t state;
    logic [1:0]    lane;
    byte_en_t      lane_byte_en;
    lsu_data_t     lane_data;
    sq_select_t    held_select;

    assign lane = retire.addr[1:0];

    // Byte enables come from the store kind and move to the addressed lane
    always_comb begin
        case (retire.func)
            SB:      lane_byte_en = byte_en_t'(4'b0001) << lane;
            SH:      lane_byte_en = byte_en_t'(4'b0011) << lane;
            SW:      lane_byte_en = '1;
            default: lane_byte_en = '0;
        endcase
    end

    // Data shifts by whole bytes into the same lane
    assign lane_data = retire.data << {lane, 3'b000};

    // Each launched store takes one WRITE cycle and then returns to IDLE
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    state <= retire.en ? WRITE : IDLE;
                WRITE:   state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Capture the aligned store when it arrives
    always_ff @(posedge clk) begin
        if (state == IDLE && retire.en) begin
            held_select      <= retire.select;
            o_commit_addr    <= retire.addr[ADDR_W-1:2];
            o_commit_byte_en <= lane_byte_en;
            o_commit_data    <= lane_data;
        end
    end

    // The queue holds its retire outputs while a store sits in WRITE
    assign retire.stall = (state == WRITE);

    // Write when memory is free, otherwise ask the queue to relaunch
    assign o_commit_en     = (state == WRITE) & ~i_mem_busy;
    assign o_update_en     = (state == WRITE);
    assign o_update_select = held_select;
    assign o_update_retry  = i_mem_busy;

endmodule

`default_nettype wire

//--- logic/lsu_store_top.sv
// Store side of the load/store unit with plain ports
// o_commit_addr is a word address, byte lanes are given by o_commit_byte_en
// The reorder buffer holds i_rob_retire_en and its tag until o_rob_retire_ack
`default_nettype none

module lsu_store_top import lsu_pkg::*; (
    input  logic            clk,
    input  logic            n_rst,
    input  logic            i_flush,
    input  logic            i_issue_en,
    input  lsu_func_t       i_issue_func,
    input  lsu_tag_t        i_issue_tag,
    input  lsu_addr_t       i_issue_base,
    input  lsu_addr_t       i_issue_offset,
    input  lsu_data_t       i_issue_data,
    output logic            o_issue_ready,
    input  logic            i_rob_retire_en,
    input  lsu_tag_t        i_rob_retire_tag,
    output logic            o_rob_retire_ack,
    input  logic            i_mem_busy,
    output logic            o_commit_en,
    output lsu_word_addr_t  o_commit_addr,
    output byte_en_t        o_commit_byte_en,
    output lsu_data_t       o_commit_data
);

    sq_alloc_if  alloc_bus ();
    sq_retire_if retire_bus ();

    // Update path from the commit stage back into the queue
    logic       update_en;
    sq_select_t update_select;
    logic       update_retry;

    store_agu u_agu (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_flush        (i_flush),
        .i_issue_en     (i_issue_en),
        .i_issue_func   (i_issue_func),
        .i_issue_tag    (i_issue_tag),
        .i_issue_base   (i_issue_base),
        .i_issue_offset (i_issue_offset),
        .i_issue_data   (i_issue_data),
        .o_issue_ready  (o_issue_ready),
        .alloc          (alloc_bus.agu)
    );

    lsu_sq u_sq (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_flush          (i_flush),
        .alloc            (alloc_bus.sq),
        .retire           (retire_bus.sq),
        .i_update_en      (update_en),
        .i_update_select  (update_select),
        .i_update_retry   (update_retry),
        .i_rob_retire_en  (i_rob_retire_en),
        .i_rob_retire_tag (i_rob_retire_tag),
        .o_rob_retire_ack (o_rob_retire_ack)
    );

    store_commit u_commit (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_mem_busy       (i_mem_busy),
        .retire           (retire_bus.commit),
        .o_update_en      (update_en),
        .o_update_select  (update_select),
        .o_update_retry   (update_retry),
        .o_commit_en      (o_commit_en),
        .o_commit_addr    (o_commit_addr),
        .o_commit_byte_en (o_commit_byte_en),
        .o_commit_data    (o_commit_data)
    );

endmodule

`default_nettype wire

//--- tests/lsu_store_props.sv
// Concurrent assertions on the store queue, attached with bind
// All properties are disabled while n_rst is low
`default_nettype none

module lsu_store_props import lsu_pkg::*; (
    input  logic       clk,
    input  logic       n_rst,
    input  logic       i_full,
    input  logic       i_alloc_en,
    input  logic       i_stall,
    input  logic       i_ret_en,
    input  sq_select_t i_ret_select,
    input  lsu_func_t  i_ret_func,
    input  lsu_addr_t  i_ret_addr,
    input  lsu_tag_t   i_ret_tag,
    input  lsu_data_t  i_ret_data,
    input  logic       i_ack,
    input  lsu_tag_t   i_rob_tag
);

    timeunit 1ns;
    timeprecision 1ps;

    // The address stage must not offer a store to a full queue
    full_blocks_alloc: assert property (@(posedge clk) disable iff (!n_rst)
        i_full |-> !i_alloc_en)
        else $error("Address stage offered a store while the queue was full");

    // The commit stage relies on the launched store holding still
    stall_holds_retire: assert property (@(posedge clk) disable iff (!n_rst)
        i_stall |=> ($stable(i_ret_en) && $stable(i_ret_select) && $stable(i_ret_func) &&
                     $stable(i_ret_addr) && $stable(i_ret_tag) && $stable(i_ret_data)))
        else $error("Retire outputs changed while the commit stage stalled");

    retire_select_onehot: assert property (@(posedge clk) disable iff (!n_rst)
        i_ret_en |-> $onehot(i_ret_select))
        else $error("Retire select is not one-hot");

    // One ack per retire request
    ack_single_pulse: assert property (@(posedge clk) disable iff (!n_rst)
        i_ack |=> !(i_ack && (i_rob_tag == $past(i_rob_tag))))
        else $error("Reorder buffer ack repeated for the same tag");

endmodule

`default_nettype wire

//--- tests/lsu_store_checker.sv
// Scoreboard on the top-level ports of the store unit
// Builds expected stores at issue, moves them to retired on ack, drops the rest on flush
// Assumes the reorder buffer never holds a retire request across a flush
`default_nettype none

module lsu_store_checker import lsu_pkg::*; (
    input  logic           clk,
    input  logic           n_rst,
    input  logic           i_flush,
    input  logic           i_issue_en,
    input  lsu_func_t      i_issue_func,
    input  lsu_tag_t       i_issue_tag,
    input  lsu_addr_t      i_issue_base,
    input  lsu_addr_t      i_issue_offset,
    input  lsu_data_t      i_issue_data,
    input  logic           i_issue_ready,
    input  logic           i_rob_retire_en,
    input  lsu_tag_t       i_rob_retire_tag,
    input  logic           i_rob_retire_ack,
    input  logic           i_commit_en,
    input  lsu_word_addr_t i_commit_addr,
    input  byte_en_t       i_commit_byte_en,
    input  lsu_data_t      i_commit_data,
    output int             o_err_count,
    output int             o_commit_count,
    output logic           o_saw_full,
    output logic           o_drained
);

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        lsu_tag_t       tag;
        lsu_word_addr_t addr;
        byte_en_t       be;
        lsu_data_t      data;
    } store_exp_t;

    store_exp_t pending_q[$];
    store_exp_t retired_q[$];
    store_exp_t exp_s;
    logic       prev_ret_en;
    lsu_tag_t   prev_ret_tag;
    lsu_data_t  mask;
    int         live;

    // Expected write from the store rules, only enabled bytes carry data
    function automatic store_exp_t expect_store(input lsu_func_t func, input lsu_tag_t tag,
                                                input lsu_addr_t base, input lsu_addr_t offset,
                                                input lsu_data_t data);
        store_exp_t e;
        lsu_addr_t  sum;
        int         lane;
        sum    = base + offset;
        lane   = int'(sum[1:0]);
        e.tag  = tag;
        e.addr = sum[ADDR_W-1:2];
        e.be   = '0;
        e.data = '0;
        if (func == SW) begin
            e.be = 4'b1111;
        end else begin
            e.be[lane] = 1'b1;
            if (func == SH) begin
                e.be[lane+1] = 1'b1;
            end
        end
        // Byte k of the store data lands in lane plus k
        for (int b = 0; b < 4; b++) begin
            if (e.be[b]) begin
                e.data[8*b +: 8] = data[8*(b-lane) +: 8];
            end
        end
        return e;
    endfunction

    function automatic lsu_data_t byte_mask(input byte_en_t be);
        lsu_data_t m;
        for (int b = 0; b < 4; b++) begin
            m[8*b +: 8] = {8{be[b]}};
        end
        return m;
    endfunction

    initial begin
        o_err_count    = 0;
        o_commit_count = 0;
        o_saw_full     = 1'b0;
        o_drained      = 1'b1;
        prev_ret_en    = 1'b0;
        prev_ret_tag   = '0;
    end

    always @(posedge clk) begin
        if (n_rst) begin
            // The agu and queue together hold SQ_DEPTH plus one stores at most
            live = pending_q.size() + retired_q.size();
            if (i_issue_ready != (live < SQ_DEPTH + 1)) begin
                $display("Fail at %0t: issue ready %0b with %0d stores held", $time,
                         i_issue_ready, live);
                o_err_count++;
            end
            if (!i_issue_ready) begin
                o_saw_full = 1'b1;
            end

            // Ack answers the request seen one edge earlier
            if (i_rob_retire_ack) begin
                if (!prev_ret_en || pending_q.size() == 0) begin
                    $display("Retire ack at %0t arrived without a pending request", $time);
                    o_err_count++;
                end else if (prev_ret_tag != pending_q[0].tag) begin
                    $display("Fail at %0t: ack for tag %0d, oldest store has tag %0d", $time,
                             prev_ret_tag, pending_q[0].tag);
                    o_err_count++;
                end else begin
                    retired_q.push_back(pending_q.pop_front());
                end
            end

            if (i_commit_en) begin
                o_commit_count++;
                if (retired_q.size() == 0) begin
                    $display("Commit at %0t with no retired store waiting", $time);
                    o_err_count++;
                end else begin
                    exp_s = retired_q.pop_front();
                    mask  = byte_mask(exp_s.be);
                    if (i_commit_addr != exp_s.addr || i_commit_byte_en != exp_s.be ||
                        (i_commit_data & mask) != exp_s.data) begin
                        $display("Fail at %0t: tag %0d wrote %h/%b/%h, expected %h/%b/%h",
                                 $time, exp_s.tag, i_commit_addr, i_commit_byte_en,
                                 i_commit_data & mask, exp_s.addr, exp_s.be, exp_s.data);
                        o_err_count++;
                    end
                end
            end

            // Unretired stores die with the flush, retired ones still commit
            if (i_flush) begin
                pending_q.delete();
            end else if (i_issue_en && i_issue_ready) begin
                pending_q.push_back(expect_store(i_issue_func, i_issue_tag, i_issue_base,
                                                 i_issue_offset, i_issue_data));
            end
        end
        prev_ret_en  = n_rst && i_rob_retire_en;
        prev_ret_tag = i_rob_retire_tag;
        o_drained    = (pending_q.size() == 0) && (retired_q.size() == 0);
    end

endmodule

`default_nettype wire

//--- tests/lsu_store_tb.sv
// Testbench for the store side of the load/store unit
// Random issue, retire gaps, rare flushes and memory busy from a fixed xorshift seed
// Retirement is held off at the start so the queue fills and back-pressure shows
`default_nettype none

module lsu_store_tb import lsu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_STORES  = 300;
    localparam int MAX_CYCLES  = NUM_STORES * 40;
    localparam int FILL_CYCLES = 30;

    logic           clk;
    logic           n_rst;
    logic           flush;
    logic           issue_en;
    lsu_func_t      issue_func;
    lsu_tag_t       issue_tag;
    lsu_addr_t      issue_base;
    lsu_addr_t      issue_offset;
    lsu_data_t      issue_data;
    logic           issue_ready;
    logic           rob_retire_en;
    lsu_tag_t       rob_retire_tag;
    logic           rob_retire_ack;
    logic           mem_busy;
    logic           commit_en;
    lsu_word_addr_t commit_addr;
    byte_en_t       commit_byte_en;
    lsu_data_t      commit_data;

    int             err_count;
    int             commit_count;
    logic           saw_full;
    logic           drained;

    logic [31:0]    rng;
    lsu_tag_t       rob_q[$];
    lsu_tag_t       next_tag;
    int             issued;
    int             cycle = 0;

    lsu_store_top dut (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_flush          (flush),
        .i_issue_en       (issue_en),
        .i_issue_func     (issue_func),
        .i_issue_tag      (issue_tag),
        .i_issue_base     (issue_base),
        .i_issue_offset   (issue_offset),
        .i_issue_data     (issue_data),
        .o_issue_ready    (issue_ready),
        .i_rob_retire_en  (rob_retire_en),
        .i_rob_retire_tag (rob_retire_tag),
        .o_rob_retire_ack (rob_retire_ack),
        .i_mem_busy       (mem_busy),
        .o_commit_en      (commit_en),
        .o_commit_addr    (commit_addr),
        .o_commit_byte_en (commit_byte_en),
        .o_commit_data    (commit_data)
    );

    lsu_store_checker u_checker (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_flush          (flush),
        .i_issue_en       (issue_en),
        .i_issue_func     (issue_func),
        .i_issue_tag      (issue_tag),
        .i_issue_base     (issue_base),
        .i_issue_offset   (issue_offset),
        .i_issue_data     (issue_data),
        .i_issue_ready    (issue_ready),
        .i_rob_retire_en  (rob_retire_en),
        .i_rob_retire_tag (rob_retire_tag),
        .i_rob_retire_ack (rob_retire_ack),
        .i_commit_en      (commit_en),
        .i_commit_addr    (commit_addr),
        .i_commit_byte_en (commit_byte_en),
        .i_commit_data    (commit_data),
        .o_err_count      (err_count),
        .o_commit_count   (commit_count),
        .o_saw_full       (saw_full),
        .o_drained        (drained)
    );

    bind lsu_sq lsu_store_props u_props (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_full         (alloc.full),
        .i_alloc_en     (alloc.en),
        .i_stall        (retire.stall),
        .i_ret_en       (retire.en),
        .i_ret_select   (retire.select),
        .i_ret_func     (retire.func),
        .i_ret_addr     (retire.addr),
        .i_ret_tag      (retire.tag),
        .i_ret_data     (retire.data),
        .i_ack          (o_rob_retire_ack),
        .i_rob_tag      (i_rob_retire_tag)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Advances the generator and returns the new value
    function automatic logic [31:0] draw();
        rng = xorshift(rng);
        return rng;
    endfunction

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        lsu_func_t func;
        lsu_addr_t base;
        lsu_addr_t offset;
        logic      do_flush;
        n_rst          = 1'b0;
        flush          = 1'b0;
        issue_en       = 1'b0;
        issue_func     = SB;
        issue_tag      = '0;
        issue_base     = '0;
        issue_offset   = '0;
        issue_data     = '0;
        rob_retire_en  = 1'b0;
        rob_retire_tag = '0;
        mem_busy       = 1'b0;
        rng            = 32'hc996cecd;
        next_tag       = '0;
        issued         = 0;
        repeat (8) @(negedge clk);
        n_rst = 1'b1;

        while (issued < NUM_STORES || rob_q.size() != 0 || !drained) begin
            @(negedge clk);
            mem_busy = (draw() % 10) < 3;

            // The reorder buffer lets go of its request once it sees the ack
            if (rob_retire_en && rob_retire_ack) begin
                rob_retire_en = 1'b0;
                void'(rob_q.pop_front());
            end

            // Flush only between retire requests, dropping every unretired store
            do_flush = !rob_retire_en && cycle > FILL_CYCLES && (draw() % 97) == 0;
            flush    = do_flush;
            if (do_flush) begin
                rob_q.delete();
            end

            if (!do_flush && !rob_retire_en && rob_q.size() != 0 && cycle > FILL_CYCLES &&
                (draw() % 2) == 1) begin
                rob_retire_en  = 1'b1;
                rob_retire_tag = rob_q[0];
            end

            // Ready is registered state, so a store driven now is taken at the next edge
            issue_en = 1'b0;
            if (!do_flush && issue_ready && issued < NUM_STORES &&
                (cycle <= FILL_CYCLES || (draw() % 10) < 6)) begin
                case (draw() % 3)
                    0:       func = SB;
                    1:       func = SH;
                    default: func = SW;
                endcase
                base   = lsu_addr_t'(draw());
                offset = lsu_addr_t'(draw());
                // Keep halfword and word stores aligned
                if (func == SH) begin
                    base[0]   = 1'b0;
                    offset[0] = 1'b0;
                end else if (func == SW) begin
                    base[1:0]   = 2'b00;
                    offset[1:0] = 2'b00;
                end
                issue_en     = 1'b1;
                issue_func   = func;
                issue_tag    = next_tag;
                issue_base   = base;
                issue_offset = offset;
                issue_data   = draw();
                rob_q.push_back(next_tag);
                next_tag = lsu_tag_t'(next_tag + 1);
                issued++;
            end
        end

        $display("Summary: %0d stores issued, %0d commits, %0d errors", issued, commit_count,
                 err_count);
        if (!saw_full) begin
            $display("The queue never filled, so back-pressure was not exercised");
        end
        if (err_count == 0 && saw_full) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- lsu_store_top.f
logic/lsu_pkg.sv
logic/lsu_ifs.sv
logic/store_agu.sv
logic/lsu_sq.sv
logic/store_commit.sv
logic/lsu_store_top.sv
tests/lsu_store_props.sv
tests/lsu_store_checker.sv
tests/lsu_store_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= lsu_store_tb
FLIST     ?= lsu_store_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Checks failed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
